// ==== bench/tb_programs.svh ====
// one row per program: twelve instruction words, then the expected stores in bus order
// memory reads answer addr * 3 + 0x1000, so lda values below follow that rule
localparam int num_programs = 5;
localparam int prog_words = 12;
localparam int max_stores = 3;

logic [31:0] code [num_programs][prog_words];
int store_count [num_programs];
mem_addr_t exp_addr [num_programs][max_stores];
word_t exp_data [num_programs][max_stores];

task automatic fill_program_table();
	// 7 + 5, 7 - 5, 7 & 5 into tagged LARs
	code[0] = '{imm_word(op_ldi, 3'd1, 16'h0007), imm_word(op_ldi, 3'd2, 16'h0005),
		imm_word(op_lda, 3'd3, 16'h0010), alu_word(op_add, 3'd3, 3'd1, 3'd2),
		imm_word(op_sta, 3'd3, 16'h0000), imm_word(op_lda, 3'd4, 16'h0011),
		alu_word(op_sub, 3'd4, 3'd1, 3'd2), imm_word(op_sta, 3'd4, 16'h0000),
		imm_word(op_lda, 3'd5, 16'h0012), alu_word(op_and, 3'd5, 3'd1, 3'd2),
		imm_word(op_sta, 3'd5, 16'h0000), imm_word(op_halt, 3'd0, 16'h0000)};
	store_count[0] = 3;
	exp_addr[0] = '{16'h0010, 16'h0011, 16'h0012};
	exp_data[0] = '{32'h0000_000c, 32'h0000_0002, 32'h0000_0005};
	// or, xor, unsigned slt on 0x00f0 and 0x0f3c
	code[1] = '{imm_word(op_ldi, 3'd1, 16'h00f0), imm_word(op_ldi, 3'd2, 16'h0f3c),
		imm_word(op_lda, 3'd3, 16'h0020), alu_word(op_or, 3'd3, 3'd1, 3'd2),
		imm_word(op_sta, 3'd3, 16'h0000), imm_word(op_lda, 3'd4, 16'h0021),
		alu_word(op_xor, 3'd4, 3'd1, 3'd2), imm_word(op_sta, 3'd4, 16'h0000),
		imm_word(op_lda, 3'd5, 16'h0022), alu_word(op_slt, 3'd5, 3'd1, 3'd2),
		imm_word(op_sta, 3'd5, 16'h0000), imm_word(op_halt, 3'd0, 16'h0000)};
	store_count[1] = 3;
	exp_addr[1] = '{16'h0020, 16'h0021, 16'h0022};
	exp_data[1] = '{32'h0000_0ffc, 32'h0000_0fcc, 32'h0000_0001};
	// read-modify-write through the tag, then an untagged store to address 0
	code[2] = '{imm_word(op_lda, 3'd1, 16'h0040), imm_word(op_ldi, 3'd2, 16'h0025),
		alu_word(op_add, 3'd1, 3'd1, 3'd2), imm_word(op_sta, 3'd1, 16'h0000),
		imm_word(op_lda, 3'd3, 16'h0123), imm_word(op_ldi, 3'd4, 16'h0100),
		alu_word(op_sub, 3'd3, 3'd3, 3'd4), imm_word(op_sta, 3'd3, 16'h0000),
		imm_word(op_ldi, 3'd7, 16'h0077), imm_word(op_sta, 3'd7, 16'h0000),
		imm_word(op_halt, 3'd0, 16'h0000), imm_word(op_halt, 3'd0, 16'h0000)};
	store_count[2] = 3;
	exp_addr[2] = '{16'h0040, 16'h0123, 16'h0000};
	exp_data[2] = '{32'h0000_10e5, 32'h0000_1269, 32'h0000_0077};
	// r1 and r2 share tag 0x50, r4 holds 0x51 and must stay untouched
	code[3] = '{imm_word(op_lda, 3'd1, 16'h0050), imm_word(op_lda, 3'd2, 16'h0050),
		imm_word(op_lda, 3'd4, 16'h0051), imm_word(op_ldi, 3'd1, 16'h0abc),
		imm_word(op_sta, 3'd2, 16'h0000), imm_word(op_ldi, 3'd3, 16'h0001),
		alu_word(op_add, 3'd2, 3'd2, 3'd3), imm_word(op_sta, 3'd1, 16'h0000),
		imm_word(op_sta, 3'd4, 16'h0000), imm_word(op_halt, 3'd0, 16'h0000),
		imm_word(op_halt, 3'd0, 16'h0000), imm_word(op_halt, 3'd0, 16'h0000)};
	store_count[3] = 3;
	exp_addr[3] = '{16'h0050, 16'h0050, 16'h0051};
	exp_data[3] = '{32'h0000_0abc, 32'h0000_0abd, 32'h0000_10f3};
	// countdown from 5, sum 5+4+3+2+1, loop body at word 4
	code[4] = '{imm_word(op_lda, 3'd2, 16'h0060), imm_word(op_ldi, 3'd2, 16'h0000),
		imm_word(op_ldi, 3'd1, 16'h0005), imm_word(op_ldi, 3'd3, 16'h0001),
		alu_word(op_add, 3'd2, 3'd2, 3'd1), alu_word(op_sub, 3'd1, 3'd1, 3'd3),
		imm_word(op_bnz, 3'd1, 16'h0004), imm_word(op_sta, 3'd2, 16'h0000),
		imm_word(op_lda, 3'd4, 16'h0061), alu_word(op_or, 3'd4, 3'd1, 3'd1),
		imm_word(op_sta, 3'd4, 16'h0000), imm_word(op_halt, 3'd0, 16'h0000)};
	store_count[4] = 2;
	exp_addr[4] = '{16'h0060, 16'h0061, 16'h0000};
	exp_data[4] = '{32'h0000_000f, 32'h0000_0000, 32'h0000_0000};
endtask

// ==== bench/lar_cpu_tb.sv ====
`timescale 1ns/1ps

module lar_cpu_tb import cpu_isa_pkg::*, lar_pkg::*;;

	logic clk;
	logic arst_n;
	pc_t instr_addr;
	instr_u instr_data;
	logic mem_req;
	logic mem_we;
	mem_addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_ack;
	logic halted;

	`include "tb_programs.svh"

	// 200 cycles per row covers reset, the program and the drain window
	localparam int cycle_limit = num_programs * 200;

	logic [31:0] rom [prog_words];
	mem_addr_t seen_addr [$];
	word_t seen_data [$];
	int ack_wait = -1;
	int cycles = 0;

	lar_cpu #(.RESET_PC(16'h0000)) DUT (.clk(clk), .arst_n(arst_n),
		.instr_addr(instr_addr), .instr_data(instr_data),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
		.halted(halted));

	always #5 clk = ~clk;

	function automatic logic [31:0] alu_word(input opcode_e op, input lar_idx_t ra,
		input lar_idx_t rb, input lar_idx_t rc);
		return {op, ra, rb, rc, 19'h0};
	endfunction

	function automatic logic [31:0] imm_word(input opcode_e op, input lar_idx_t ra,
		input logic [15:0] imm);
		return {op, ra, 9'h0, imm};
	endfunction

	// past the program the rom answers halt with the address in the immediate
	function automatic logic [31:0] rom_word(input pc_t a);
		if (a < pc_t'(prog_words))
			return rom[a[3:0]];
		return imm_word(op_halt, 3'd0, a);
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_store(input mem_addr_t got_addr, input word_t got_data,
		input mem_addr_t want_addr, input word_t want_data, input int idx);
		if (got_addr !== want_addr || got_data !== want_data)
			report_failure($sformatf("Mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, idx, got_data, got_addr, want_data, want_addr));
	endtask

	task automatic check_idle(input bit got, input bit want, input string what);
		if (got !== want)
			report_failure($sformatf("Mismatch at %0t: %s is %0b, expected %0b",
				$time, what, got, want));
	endtask

	task automatic check_count(input int got, input int want, input string what);
		if (got != want)
			report_failure($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
				$time, what, got, want));
	endtask

	// rom word settles before the next rising edge
	always @(negedge clk)
		instr_data = instr_u'(rom_word(instr_addr));

	// data memory acks after 0 to 3 idle cycles
	// stores are logged in bus order
	always @(negedge clk) begin
		if (!arst_n || !mem_req || mem_ack) begin
			mem_ack = 1'b0;
			ack_wait = -1;
		end else begin
			if (ack_wait < 0)
				ack_wait = $urandom % 4;
			if (ack_wait == 0) begin
				mem_ack = 1'b1;
				mem_rdata = word_t'(mem_addr) * 32'd3 + 32'h0000_1000;
				if (mem_we) begin
					seen_addr.push_back(mem_addr);
					seen_data.push_back(mem_wdata);
				end
			end else begin
				ack_wait--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit)
			report_failure($sformatf("Timeout: run still going after %0d cycles", cycle_limit));
	end

	task automatic run_program(input int p);
		int at_halt;
		@(negedge clk);
		arst_n = 1'b0;
		for (int i = 0; i < prog_words; i++)
			rom[i] = code[p][i];
		seen_addr.delete();
		seen_data.delete();
		repeat (3) @(negedge clk);
		check_idle(mem_req, 1'b0, "mem_req after reset");
		check_idle(halted, 1'b0, "halted after reset");
		arst_n = 1'b1;
		while (!halted)
			@(negedge clk);
		at_halt = seen_addr.size();
		// halted must hold and the bus stay quiet
		repeat (10) @(negedge clk);
		check_idle(halted, 1'b1, "halted after drain");
		check_idle(mem_req, 1'b0, "mem_req after halt");
		check_count(seen_addr.size(), at_halt, "store count after halted");
		check_count(seen_addr.size(), store_count[p], $sformatf("program %0d store count", p));
		for (int k = 0; k < store_count[p]; k++)
			check_store(seen_addr[k], seen_data[k], exp_addr[p][k], exp_data[p][k], k);
	endtask

	initial begin
		void'($urandom(32'h808f));
		clk = 1'b0;
		arst_n = 1'b0;
		instr_data = '0;
		mem_rdata = '0;
		mem_ack = 1'b0;
		fill_program_table();
		for (int p = 0; p < num_programs; p++)
			run_program(p);
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== design/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// instruction word address
	typedef logic [15:0] pc_t;

	// major opcode, top nibble of every instruction word
	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_and  = 4'h2,
		op_or   = 4'h3,
		op_xor  = 4'h4,
		// unsigned set-less-than
		op_slt  = 4'h5,
		// zero-extended 16-bit immediate into data
		op_ldi  = 4'h6,
		// set tag from immediate, read memory into data
		op_lda  = 4'h7,
		// write data to the tag address
		op_sta  = 4'h8,
		// branch if ra data nonzero
		op_bnz  = 4'h9,
		op_halt = 4'ha
	} opcode_e;

	// three-index view
	// ra is the destination, rb and rc are the sources
	typedef struct packed {
		opcode_e opcode;
		lar_pkg::lar_idx_t ra;
		lar_pkg::lar_idx_t rb;
		lar_pkg::lar_idx_t rc;
		logic [18:0] unused;
	} alu_fmt_t;

	// one index plus immediate
	// imm is a data address for lda or a branch target for bnz
	typedef struct packed {
		opcode_e opcode;
		lar_pkg::lar_idx_t ra;
		logic [8:0] unused;
		logic [15:0] imm;
	} imm_fmt_t;

	// same 32-bit word seen through either format
	typedef union packed {
		alu_fmt_t alu_fmt;
		imm_fmt_t imm_fmt;
	} instr_u;

endpackage

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_isa_pkg::*, lar_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic issue,
	input  instr_u issue_instr,
	input  lar_meta_t rd_a_meta,
	input  word_t rd_a_data,
	input  word_t rd_b_data,
	input  logic hold,
	output logic redirect,
	output pc_t redirect_pc,
	output logic busy,
	output lar_idx_t dst,
	output logic writes,
	output logic wb_valid,
	output opcode_e wb_op,
	output lar_idx_t wb_idx,
	output word_t wb_data,
	output mem_addr_t wb_addr
);
	// operand register, filled at the issue edge
	logic ex_valid;
	instr_u ex_instr;
	lar_meta_t ex_a_meta;
	word_t ex_a_data;
	word_t ex_b_data;
	opcode_e ex_op;
	logic ex_writes_lar;
	logic ex_needs_wb;
	word_t result;
	mem_addr_t addr;

	assign ex_op = ex_instr.alu_fmt.opcode;
	assign ex_writes_lar = ex_op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt,
		op_ldi, op_lda};
	assign ex_needs_wb = ex_writes_lar || (ex_op == op_sta);

	assign busy = ex_valid;
	assign dst = ex_instr.alu_fmt.ra;
	assign writes = ex_valid && ex_writes_lar;

	// bnz tests ra data, no delay slot
	assign redirect = ex_valid && !hold && (ex_op == op_bnz) && (ex_a_data != '0);
	assign redirect_pc = ex_instr.imm_fmt.imm;

	// port a is rb for alu ops and ra for sta
	always_comb begin
		result = '0;
		addr = '0;
		case (ex_op)
			op_add: result = ex_a_data + ex_b_data;
			op_sub: result = ex_a_data - ex_b_data;
			op_and: result = ex_a_data & ex_b_data;
			op_or:  result = ex_a_data | ex_b_data;
			op_xor: result = ex_a_data ^ ex_b_data;
			op_slt: result = {31'b0, ex_a_data < ex_b_data};
			op_ldi: result = {16'b0, ex_instr.imm_fmt.imm};
			op_lda: addr = ex_instr.imm_fmt.imm;
			op_sta: begin
				result = ex_a_data;
				// untagged store goes to address 0
				addr = ex_a_meta.tag_valid ? ex_a_meta.tag : '0;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			if (issue)
				ex_valid <= 1'b1;
			else if (!hold)
				ex_valid <= 1'b0;
			// bnz and unknown opcodes end here
			if (!hold)
				wb_valid <= ex_valid && ex_needs_wb;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			ex_instr <= issue_instr;
			ex_a_meta <= rd_a_meta;
			ex_a_data <= rd_a_data;
			ex_b_data <= rd_b_data;
		end
		if (!hold) begin
			wb_op <= ex_op;
			wb_idx <= ex_instr.alu_fmt.ra;
			wb_data <= result;
			wb_addr <= addr;
		end
	end

endmodule

// ==== design/instr_fetch_decode.sv ====
`timescale 1ns/1ps

module instr_fetch_decode import cpu_isa_pkg::*, lar_pkg::*; #(
	parameter pc_t RESET_PC = '0
) (
	input  logic clk,
	input  logic arst_n,
	output pc_t instr_addr,
	input  instr_u instr_data,
	input  logic ex_busy,
	input  lar_idx_t ex_dst,
	input  logic ex_writes,
	input  logic wb_busy,
	input  lar_idx_t wb_dst,
	input  logic wb_writes,
	input  logic redirect,
	input  pc_t redirect_pc,
	output lar_idx_t rd_a_idx,
	output lar_idx_t rd_b_idx,
	output logic issue,
	output instr_u issue_instr,
	output logic halted
);
	pc_t pc;
	logic dec_valid;
	instr_u dec_instr;
	opcode_e dec_op;
	logic dec_is_alu;
	logic dec_halt;
	logic reads_a;
	logic reads_b;
	logic hit_a;
	logic hit_b;
	logic collide;
	logic later_empty;

	// rom answers in the same cycle
	assign instr_addr = pc;
	assign dec_op = dec_instr.alu_fmt.opcode;
	assign dec_is_alu = dec_op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt};
	assign dec_halt = dec_valid && (dec_op == op_halt);

	// alu ops read rb and rc, sta and bnz read ra through port a
	assign rd_a_idx = dec_is_alu ? dec_instr.alu_fmt.rb : dec_instr.imm_fmt.ra;
	assign rd_b_idx = dec_instr.alu_fmt.rc;
	assign reads_a = dec_is_alu || (dec_op == op_sta) || (dec_op == op_bnz);
	assign reads_b = dec_is_alu;

	// source against pending destinations
	assign hit_a = (ex_writes && (ex_dst == rd_a_idx)) || (wb_writes && (wb_dst == rd_a_idx));
	assign hit_b = (ex_writes && (ex_dst == rd_b_idx)) || (wb_writes && (wb_dst == rd_b_idx));
	assign collide = (reads_a && hit_a) || (reads_b && hit_b);

	// one instruction in flight past decode at a time
	// shared tags can alias a source with any pending write
	assign later_empty = !ex_busy && !wb_busy;
	assign issue = dec_valid && !dec_halt && later_empty && !collide;
	assign issue_instr = dec_instr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
			dec_valid <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (redirect) begin
				// taken branch, drop the wrong-path word
				pc <= redirect_pc;
				dec_valid <= 1'b0;
			end else if (!dec_valid || issue) begin
				pc <= pc + pc_t'(1);
				dec_valid <= 1'b1;
			end
			// halt parks in decode, so fetch stops
			if (dec_halt && later_empty)
				halted <= 1'b1;
		end
	end

	// decode word follows the valid bit
	always_ff @(posedge clk) begin
		if (!redirect && (!dec_valid || issue))
			dec_instr <= instr_data;
	end

endmodule

// ==== design/lar_cpu.sv ====
`timescale 1ns/1ps

module lar_cpu import cpu_isa_pkg::*, lar_pkg::*; #(
	parameter pc_t RESET_PC = '0
) (
	input  logic clk,
	input  logic arst_n,
	output pc_t instr_addr,
	input  instr_u instr_data,
	output logic mem_req,
	output logic mem_we,
	output mem_addr_t mem_addr,
	output word_t mem_wdata,
	input  word_t mem_rdata,
	input  logic mem_ack,
	output logic halted
);
	// decode to lar file and execute
	lar_idx_t rd_a_idx, rd_b_idx;
	lar_meta_t rd_a_meta;
	word_t rd_a_data, rd_b_data;
	logic issue;
	instr_u issue_instr;

	// execute and writeback back to decode
	logic ex_busy, ex_writes, wb_busy, wb_writes;
	lar_idx_t ex_dst, wb_dst;
	logic redirect;
	pc_t redirect_pc;

	// execute result register
	logic wb_valid, hold;
	opcode_e wb_op;
	lar_idx_t wb_idx;
	word_t wb_data;
	mem_addr_t wb_addr;

	// writeback to lar file
	logic wr_en, wr_tag_en;
	lar_idx_t wr_idx;
	word_t wr_data;
	mem_addr_t wr_tag;

	// writeback to bus guard
	logic bus_start, bus_we, bus_done;
	mem_addr_t bus_addr;
	word_t bus_wdata, bus_rdata;

	instr_fetch_decode #(.RESET_PC(RESET_PC)) inst_fetch_decode (.clk(clk), .arst_n(arst_n),
		.instr_addr(instr_addr), .instr_data(instr_data),
		.ex_busy(ex_busy), .ex_dst(ex_dst), .ex_writes(ex_writes),
		.wb_busy(wb_busy), .wb_dst(wb_dst), .wb_writes(wb_writes),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
		.issue(issue), .issue_instr(issue_instr), .halted(halted));

	lar_file inst_lar_file (.clk(clk), .arst_n(arst_n),
		.rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
		.rd_a_meta(rd_a_meta), .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.wr_tag_en(wr_tag_en), .wr_tag(wr_tag));

	execute_stage inst_execute (.clk(clk), .arst_n(arst_n),
		.issue(issue), .issue_instr(issue_instr),
		.rd_a_meta(rd_a_meta), .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
		.hold(hold), .redirect(redirect), .redirect_pc(redirect_pc),
		.busy(ex_busy), .dst(ex_dst), .writes(ex_writes),
		.wb_valid(wb_valid), .wb_op(wb_op), .wb_idx(wb_idx),
		.wb_data(wb_data), .wb_addr(wb_addr));

	writeback_stage inst_writeback (.clk(clk), .arst_n(arst_n),
		.wb_valid(wb_valid), .wb_op(wb_op), .wb_idx(wb_idx),
		.wb_data(wb_data), .wb_addr(wb_addr),
		.hold(hold), .busy(wb_busy), .dst(wb_dst), .writes(wb_writes),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.wr_tag_en(wr_tag_en), .wr_tag(wr_tag),
		.start(bus_start), .we(bus_we), .addr(bus_addr), .wdata(bus_wdata),
		.done(bus_done), .rdata(bus_rdata));

	// only block on the external data bus
	mem_bus_guard inst_mem_bus_guard (.clk(clk), .arst_n(arst_n),
		.start(bus_start), .we(bus_we), .addr(bus_addr), .wdata(bus_wdata),
		.done(bus_done), .rdata(bus_rdata),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack));

endmodule

// ==== design/lar_file.sv ====
`timescale 1ns/1ps

module lar_file import lar_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  lar_idx_t rd_a_idx,
	input  lar_idx_t rd_b_idx,
	output lar_meta_t rd_a_meta,
	output word_t rd_a_data,
	output word_t rd_b_data,
	input  logic wr_en,
	input  lar_idx_t wr_idx,
	input  word_t wr_data,
	input  logic wr_tag_en,
	input  mem_addr_t wr_tag
);
	lar_meta_t meta [num_lars];
	word_t data [num_lars];
	mem_addr_t share_tag;
	logic share_valid;
	logic [num_lars-1:0] hit;

	// combinational reads, old value during a write
	assign rd_a_meta = meta[rd_a_idx];
	assign rd_a_data = data[rd_a_idx];
	assign rd_b_data = data[rd_b_idx];

	// tag that decides who shares the written data
	// lda brings a new tag, other writes use the target's own
	always_comb begin
		share_tag = wr_tag_en ? wr_tag : meta[wr_idx].tag;
		share_valid = wr_tag_en || meta[wr_idx].tag_valid;
		for (int i = 0; i < num_lars; i++) begin
			hit[i] = wr_en && ((lar_idx_t'(i) == wr_idx) ||
				(share_valid && meta[i].tag_valid && (meta[i].tag == share_tag)));
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < num_lars; i++) begin
				meta[i] <= '0;
				data[i] <= '0;
			end
		end else begin
			// target plus every valid sharer
			for (int i = 0; i < num_lars; i++) begin
				if (hit[i])
					data[i] <= wr_data;
			end
			if (wr_en && wr_tag_en)
				meta[wr_idx] <= '{tag: wr_tag, tag_valid: 1'b1};
		end
	end

endmodule

// ==== design/lar_pkg.sv ====
package lar_pkg;

	// selects one of the address registers
	typedef logic [2:0] lar_idx_t;

	// number of address registers in the file
	localparam int num_lars = 1 << $bits(lar_idx_t);

	// data held by a LAR
	typedef logic [31:0] word_t;

	// data memory word address
	typedef logic [15:0] mem_addr_t;

	// per-LAR metadata
	// data is shared between LARs whose valid tags match
	typedef struct packed {
		mem_addr_t tag;
		logic tag_valid;
	} lar_meta_t;

endpackage

// ==== design/mem_bus_guard.sv ====
`timescale 1ns/1ps

module mem_bus_guard import lar_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  logic we,
	input  mem_addr_t addr,
	input  word_t wdata,
	output logic done,
	output word_t rdata,
	output logic mem_req,
	output logic mem_we,
	output mem_addr_t mem_addr,
	output word_t mem_wdata,
	input  word_t mem_rdata,
	input  logic mem_ack
);
	logic accept;
	logic ack_seen;

	// new request only while the bus is idle
	assign accept = start && !mem_req;
	assign ack_seen = mem_req && mem_ack;

	// request level and done pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_req <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= ack_seen;
			if (accept)
				mem_req <= 1'b1;
			else if (ack_seen)
				mem_req <= 1'b0;
		end
	end

	// address, enable and write data held stable while mem_req is up
	always_ff @(posedge clk) begin
		if (accept) begin
			mem_we <= we;
			mem_addr <= addr;
			mem_wdata <= wdata;
		end
		// read data only valid in the ack cycle
		if (ack_seen)
			rdata <= mem_rdata;
	end

endmodule

// ==== design/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage import cpu_isa_pkg::*, lar_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic wb_valid,
	input  opcode_e wb_op,
	input  lar_idx_t wb_idx,
	input  word_t wb_data,
	input  mem_addr_t wb_addr,
	output logic hold,
	output logic busy,
	output lar_idx_t dst,
	output logic writes,
	output logic wr_en,
	output lar_idx_t wr_idx,
	output word_t wr_data,
	output logic wr_tag_en,
	output mem_addr_t wr_tag,
	output logic start,
	output logic we,
	output mem_addr_t addr,
	output word_t wdata,
	input  logic done,
	input  word_t rdata
);
	logic is_mem;
	logic is_lda;
	logic writes_lar;
	// request handed to the guard, waiting for done
	logic pending;

	assign is_mem = wb_op inside {op_lda, op_sta};
	assign is_lda = wb_op == op_lda;
	assign writes_lar = wb_op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt,
		op_ldi, op_lda};

	assign busy = wb_valid;
	assign dst = wb_idx;
	assign writes = wb_valid && writes_lar;

	// one start per memory op, then stall execute until done
	assign start = wb_valid && is_mem && !pending;
	assign hold = wb_valid && is_mem && !done;
	assign we = wb_op == op_sta;
	assign addr = wb_addr;
	assign wdata = wb_data;

	// alu and ldi write at once, lda writes tag and data on done
	assign wr_en = wb_valid && writes_lar && (!is_mem || done);
	assign wr_idx = wb_idx;
	assign wr_data = is_lda ? rdata : wb_data;
	assign wr_tag_en = wb_valid && is_lda && done;
	assign wr_tag = wb_addr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pending <= 1'b0;
		else if (start)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench, the log decides pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module lar_cpu_tb -Mdir obj_dir -o lar_cpu_sim &&
./obj_dir/lar_cpu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

// ==== sources.f ====
+incdir+bench
design/lar_pkg.sv
design/cpu_isa_pkg.sv
design/instr_fetch_decode.sv
design/lar_file.sv
design/execute_stage.sv
design/writeback_stage.sv
design/mem_bus_guard.sv
design/lar_cpu.sv
bench/lar_cpu_tb.sv
